// File: logic/video_timing_pkg.sv
/*
 * Raster timing types and default 640x480 at 60 Hz timing values.
 * Coordinates are 10 bits, so a line or a frame total must stay below 1024.
 * Sync polarity is active low throughout the design.
 */
`default_nettype none

package video_timing_pkg;

    // Pixel column or line number
    typedef logic [9:0] coord_t;

    // Horizontal phases of one line, in raster order
    typedef enum logic [1:0] {
        ACTIVE,
        FRONT_PORCH,
        SYNC,
        BACK_PORCH
    } h_phase_t;

    // ======================================================================
    // Default 640x480 timing (25.175 MHz nominal pixel clock)
    // ======================================================================
    parameter int DEF_H_ACTIVE = 640;
    parameter int DEF_H_FP     = 16;
    parameter int DEF_H_SYNC   = 96;
    parameter int DEF_H_BP     = 48;

    parameter int DEF_V_ACTIVE = 480;
    parameter int DEF_V_FP     = 10;
    parameter int DEF_V_SYNC   = 2;
    parameter int DEF_V_BP     = 33;

endpackage

`default_nettype wire

// File: logic/pixel_pkg.sv
/*
 * Pixel formats, test pattern modes and colour conversion constants.
 * The HDMI word carries chroma in the upper byte and luma in the lower byte.
 * Conversion coefficients are BT.601 studio range, scaled by 256.
 */
`default_nettype none

package pixel_pkg;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] c;
        logic [7:0] y;
    } ycbcr_word_t;

    typedef enum logic [1:0] {
        PAT_GRADIENT,
        PAT_GRADIENT_RECT,
        PAT_BLACK
    } pattern_mode_t;

    // Pure red
    parameter rgb565_t RECT_COLOR = '{r: 5'd31, g: 6'd0, b: 5'd0};

    // Black in YCbCr, sent whenever de is low
    parameter ycbcr_word_t BLANK_WORD = '{c: 8'd128, y: 8'd16};

    // Centred 80x80 rectangle on a 640x480 screen
    parameter int DEF_RECT_X0 = 280;
    parameter int DEF_RECT_X1 = 359;
    parameter int DEF_RECT_Y0 = 200;
    parameter int DEF_RECT_Y1 = 279;

    // ======================================================================
    // RGB to YCbCr arithmetic
    // ======================================================================
    typedef logic signed [17:0] ycc_acc_t;

    parameter ycc_acc_t COEF_Y_R  = 18'sd66;
    parameter ycc_acc_t COEF_Y_G  = 18'sd129;
    parameter ycc_acc_t COEF_Y_B  = 18'sd25;
    parameter ycc_acc_t COEF_CB_R = -18'sd38;
    parameter ycc_acc_t COEF_CB_G = -18'sd74;
    parameter ycc_acc_t COEF_CB_B = 18'sd112;
    parameter ycc_acc_t COEF_CR_R = 18'sd112;
    parameter ycc_acc_t COEF_CR_G = -18'sd94;
    parameter ycc_acc_t COEF_CR_B = -18'sd18;
    parameter ycc_acc_t ROUND_BIAS = 18'sd128;

    parameter logic [7:0] Y_OFFSET = 8'd16;
    parameter logic [7:0] C_OFFSET = 8'd128;

endpackage

`default_nettype wire

// File: logic/video_timing_gen.sv
/*
 * Raster timing generator with registered sync, enable and coordinates.
 * Every porch and sync width must be at least one cycle.
 * Line and frame totals must fit the 10-bit coordinate type.
 * frame_start_o is a one-cycle strobe aligned with pixel (0,0).
 */
`default_nettype none

module video_timing_gen #(
    parameter int H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter int H_FP     = video_timing_pkg::DEF_H_FP,
    parameter int H_SYNC   = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BP     = video_timing_pkg::DEF_H_BP,
    parameter int V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE,
    parameter int V_FP     = video_timing_pkg::DEF_V_FP,
    parameter int V_SYNC   = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BP     = video_timing_pkg::DEF_V_BP
) (
    input  logic                     pixel_clk,
    input  logic                     rst_pixel_n,
    output video_timing_pkg::coord_t x_o,
    output video_timing_pkg::coord_t y_o,
    output logic                     de_o,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     frame_start_o
);

    import video_timing_pkg::*;

    localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int V_SYNC_START = V_ACTIVE + V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    h_phase_t h_phase;
    h_phase_t h_phase_next;
    coord_t   h_cnt;
    coord_t   v_cnt;
    logic     phase_end;
    logic     line_end;
    logic     in_vsync;

    // ======================================================================
    // Horizontal phase tracking
    // ======================================================================
    // Each phase ends on the last column that belongs to it
    always_comb begin
        case (h_phase)
            ACTIVE: begin
                phase_end    = (h_cnt == coord_t'(H_ACTIVE - 1));
                h_phase_next = FRONT_PORCH;
            end
            FRONT_PORCH: begin
                phase_end    = (h_cnt == coord_t'(H_ACTIVE + H_FP - 1));
                h_phase_next = SYNC;
            end
            SYNC: begin
                phase_end    = (h_cnt == coord_t'(H_ACTIVE + H_FP + H_SYNC - 1));
                h_phase_next = BACK_PORCH;
            end
            default: begin
                phase_end    = (h_cnt == coord_t'(H_TOTAL - 1));
                h_phase_next = ACTIVE;
            end
        endcase
    end

    assign line_end = (h_phase == BACK_PORCH) && phase_end;

    always_ff @(posedge pixel_clk or negedge rst_pixel_n) begin
        if (!rst_pixel_n) begin
            h_phase <= ACTIVE;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else begin
            if (phase_end) begin
                h_phase <= h_phase_next;
            end
            if (line_end) begin
                h_cnt <= '0;
                if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ======================================================================
    // Registered decode
    // ======================================================================
    assign in_vsync = (v_cnt >= coord_t'(V_SYNC_START)) && (v_cnt < coord_t'(V_SYNC_END));

    always_ff @(posedge pixel_clk or negedge rst_pixel_n) begin
        if (!rst_pixel_n) begin
            x_o           <= '0;
            y_o           <= '0;
            de_o          <= 1'b0;
            hsync_o       <= 1'b1;
            vsync_o       <= 1'b1;
            frame_start_o <= 1'b0;
        end else begin
            x_o           <= h_cnt;
            y_o           <= v_cnt;
            de_o          <= (h_phase == ACTIVE) && (v_cnt < coord_t'(V_ACTIVE));
            hsync_o       <= (h_phase != SYNC);
            vsync_o       <= !in_vsync;
            frame_start_o <= (h_cnt == '0) && (v_cnt == '0);
        end
    end

endmodule

`default_nettype wire

// File: logic/test_pattern_source.sv
/*
 * Per-pixel gradient test pattern with an optional solid rectangle.
 * The mode is taken on the frame-start strobe, so it changes only
 * between frames. Output lags the inputs by one cycle.
 */
`default_nettype none

module test_pattern_source #(
    parameter int RECT_X0 = pixel_pkg::DEF_RECT_X0,
    parameter int RECT_X1 = pixel_pkg::DEF_RECT_X1,
    parameter int RECT_Y0 = pixel_pkg::DEF_RECT_Y0,
    parameter int RECT_Y1 = pixel_pkg::DEF_RECT_Y1
) (
    input  logic                     pixel_clk,
    input  logic                     rst_pixel_n,
    input  pixel_pkg::pattern_mode_t mode_i,
    input  video_timing_pkg::coord_t x_i,
    input  video_timing_pkg::coord_t y_i,
    input  logic                     de_i,
    input  logic                     hsync_i,
    input  logic                     vsync_i,
    input  logic                     frame_start_i,
    output pixel_pkg::rgb565_t       rgb_o,
    output logic                     de_o,
    output logic                     hsync_o,
    output logic                     vsync_o
);

    import pixel_pkg::*;
    import video_timing_pkg::*;

    pattern_mode_t mode_q;
    pattern_mode_t mode_cur;
    rgb565_t       pix;
    logic          in_rect;

    // The strobed pixel already sees the new mode
    assign mode_cur = frame_start_i ? mode_i : mode_q;

    assign in_rect = (x_i >= coord_t'(RECT_X0)) && (x_i <= coord_t'(RECT_X1)) &&
                     (y_i >= coord_t'(RECT_Y0)) && (y_i <= coord_t'(RECT_Y1));

    // ======================================================================
    // Pixel colour
    // ======================================================================
    always_comb begin
        // Red follows x, green follows y, blue is a 32-pixel checkerboard
        pix.r = x_i[9:5];
        pix.g = y_i[8:3];
        pix.b = (x_i[5] ^ y_i[5]) ? 5'd31 : 5'd0;

        if (!de_i) begin
            pix = '0;
        end else begin
            case (mode_cur)
                PAT_GRADIENT_RECT: begin
                    if (in_rect) begin
                        pix = RECT_COLOR;
                    end
                end
                PAT_BLACK: pix = '0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge pixel_clk or negedge rst_pixel_n) begin
        if (!rst_pixel_n) begin
            mode_q  <= PAT_BLACK;
            de_o    <= 1'b0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            if (frame_start_i) begin
                mode_q <= mode_i;
            end
            de_o    <= de_i;
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
        end
    end

    always_ff @(posedge pixel_clk) begin
        rgb_o <= pix;
    end

endmodule

`default_nettype wire

// File: logic/rgb_to_ycbcr422.sv
/*
 * RGB565 to YCbCr 4:2:2 conversion feeding the HDMI output registers.
 * Two cycles from input to output. Chroma restarts with Cb at the first
 * pixel of every active run; outside de the word is forced to black.
 */
`default_nettype none

module rgb_to_ycbcr422 (
    input  logic                   pixel_clk,
    input  logic                   rst_pixel_n,
    input  pixel_pkg::rgb565_t     rgb_i,
    input  logic                   de_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    output pixel_pkg::ycbcr_word_t hdmi_d_o,
    output logic                   hdmi_de_o,
    output logic                   hdmi_hsync_o,
    output logic                   hdmi_vsync_o
);

    import pixel_pkg::*;

    logic [7:0] r8;
    logic [7:0] g8;
    logic [7:0] b8;
    ycc_acc_t   r_s;
    ycc_acc_t   g_s;
    ycc_acc_t   b_s;

    ycc_acc_t   y_acc;
    ycc_acc_t   cb_acc;
    ycc_acc_t   cr_acc;
    logic       de_s1;
    logic       hsync_s1;
    logic       vsync_s1;

    ycc_acc_t   y_rnd;
    ycc_acc_t   cb_rnd;
    ycc_acc_t   cr_rnd;
    logic [7:0] y8;
    logic [7:0] cb8;
    logic [7:0] cr8;
    logic       chroma_sel;

    // ======================================================================
    // Stage 1: expand to 8 bits and weight
    // ======================================================================
    // Top bits are replicated so full scale maps to 255
    assign r8 = {rgb_i.r, rgb_i.r[4:2]};
    assign g8 = {rgb_i.g, rgb_i.g[5:4]};
    assign b8 = {rgb_i.b, rgb_i.b[4:2]};

    assign r_s = {10'd0, r8};
    assign g_s = {10'd0, g8};
    assign b_s = {10'd0, b8};

    always_ff @(posedge pixel_clk) begin
        y_acc  <= COEF_Y_R * r_s + COEF_Y_G * g_s + COEF_Y_B * b_s;
        cb_acc <= COEF_CB_R * r_s + COEF_CB_G * g_s + COEF_CB_B * b_s;
        cr_acc <= COEF_CR_R * r_s + COEF_CR_G * g_s + COEF_CR_B * b_s;
    end

    always_ff @(posedge pixel_clk or negedge rst_pixel_n) begin
        if (!rst_pixel_n) begin
            de_s1    <= 1'b0;
            hsync_s1 <= 1'b1;
            vsync_s1 <= 1'b1;
        end else begin
            de_s1    <= de_i;
            hsync_s1 <= hsync_i;
            vsync_s1 <= vsync_i;
        end
    end

    // ======================================================================
    // Stage 2: round, offset and select chroma
    // ======================================================================
    assign y_rnd  = (y_acc + ROUND_BIAS) >>> 8;
    assign cb_rnd = (cb_acc + ROUND_BIAS) >>> 8;
    assign cr_rnd = (cr_acc + ROUND_BIAS) >>> 8;

    // Chroma differences are signed, wrapping into the offset is intended
    assign y8  = Y_OFFSET + y_rnd[7:0];
    assign cb8 = C_OFFSET + cb_rnd[7:0];
    assign cr8 = C_OFFSET + cr_rnd[7:0];

    always_ff @(posedge pixel_clk or negedge rst_pixel_n) begin
        if (!rst_pixel_n) begin
            chroma_sel   <= 1'b0;
            hdmi_d_o     <= BLANK_WORD;
            hdmi_de_o    <= 1'b0;
            hdmi_hsync_o <= 1'b1;
            hdmi_vsync_o <= 1'b1;
        end else begin
            // Low selects Cb, so every run starts on Cb
            chroma_sel <= de_s1 ? ~chroma_sel : 1'b0;
            if (de_s1) begin
                hdmi_d_o <= '{c: (chroma_sel ? cr8 : cb8), y: y8};
            end else begin
                hdmi_d_o <= BLANK_WORD;
            end
            hdmi_de_o    <= de_s1;
            hdmi_hsync_o <= hsync_s1;
            hdmi_vsync_o <= vsync_s1;
        end
    end

endmodule

`default_nettype wire

// File: logic/hdmi_video_top.sv
/*
 * Pixel-clock video path: timing generator, test pattern, YCbCr output.
 * HDMI outputs trail the raster counters by three cycles.
 * pattern_mode_i takes effect at the next frame start.
 */
`default_nettype none

module hdmi_video_top #(
    parameter int H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter int H_FP     = video_timing_pkg::DEF_H_FP,
    parameter int H_SYNC   = video_timing_pkg::DEF_H_SYNC,
    parameter int H_BP     = video_timing_pkg::DEF_H_BP,
    parameter int V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE,
    parameter int V_FP     = video_timing_pkg::DEF_V_FP,
    parameter int V_SYNC   = video_timing_pkg::DEF_V_SYNC,
    parameter int V_BP     = video_timing_pkg::DEF_V_BP,
    parameter int RECT_X0  = pixel_pkg::DEF_RECT_X0,
    parameter int RECT_X1  = pixel_pkg::DEF_RECT_X1,
    parameter int RECT_Y0  = pixel_pkg::DEF_RECT_Y0,
    parameter int RECT_Y1  = pixel_pkg::DEF_RECT_Y1
) (
    input  logic                     pixel_clk,
    input  logic                     rst_pixel_n,
    input  pixel_pkg::pattern_mode_t pattern_mode_i,
    output pixel_pkg::ycbcr_word_t   hdmi_d_o,
    output logic                     hdmi_de_o,
    output logic                     hdmi_hsync_o,
    output logic                     hdmi_vsync_o
);

    import video_timing_pkg::*;
    import pixel_pkg::*;

    coord_t  tim_x;
    coord_t  tim_y;
    logic    tim_de;
    logic    tim_hsync;
    logic    tim_vsync;
    logic    tim_frame_start;

    rgb565_t pat_rgb;
    logic    pat_de;
    logic    pat_hsync;
    logic    pat_vsync;

    video_timing_gen #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) video_timing_gen_inst (
        .pixel_clk     (pixel_clk),
        .rst_pixel_n   (rst_pixel_n),
        .x_o           (tim_x),
        .y_o           (tim_y),
        .de_o          (tim_de),
        .hsync_o       (tim_hsync),
        .vsync_o       (tim_vsync),
        .frame_start_o (tim_frame_start)
    );

    test_pattern_source #(
        .RECT_X0 (RECT_X0),
        .RECT_X1 (RECT_X1),
        .RECT_Y0 (RECT_Y0),
        .RECT_Y1 (RECT_Y1)
    ) test_pattern_source_inst (
        .pixel_clk     (pixel_clk),
        .rst_pixel_n   (rst_pixel_n),
        .mode_i        (pattern_mode_i),
        .x_i           (tim_x),
        .y_i           (tim_y),
        .de_i          (tim_de),
        .hsync_i       (tim_hsync),
        .vsync_i       (tim_vsync),
        .frame_start_i (tim_frame_start),
        .rgb_o         (pat_rgb),
        .de_o          (pat_de),
        .hsync_o       (pat_hsync),
        .vsync_o       (pat_vsync)
    );

    rgb_to_ycbcr422 rgb_to_ycbcr422_inst (
        .pixel_clk    (pixel_clk),
        .rst_pixel_n  (rst_pixel_n),
        .rgb_i        (pat_rgb),
        .de_i         (pat_de),
        .hsync_i      (pat_hsync),
        .vsync_i      (pat_vsync),
        .hdmi_d_o     (hdmi_d_o),
        .hdmi_de_o    (hdmi_de_o),
        .hdmi_hsync_o (hdmi_hsync_o),
        .hdmi_vsync_o (hdmi_vsync_o)
    );

endmodule

`default_nettype wire

// File: tests/hdmi_video_properties.sv
/*
 * Concurrent checks on the HDMI outputs, bound into hdmi_video_top.
 * H_SYNC is taken from the bound instance, so the pulse check follows its timing.
 * fail_count is read by the testbench for its final summary.
 */
`default_nettype none

module hdmi_video_properties #(
    parameter int H_SYNC = video_timing_pkg::DEF_H_SYNC
) (
    input logic                   pixel_clk,
    input logic                   rst_pixel_n,
    input pixel_pkg::ycbcr_word_t hdmi_d_o,
    input logic                   hdmi_de_o,
    input logic                   hdmi_hsync_o,
    input logic                   hdmi_vsync_o
);

    import pixel_pkg::*;

    int fail_count = 0;

    // Outside the active area only the blanking word is sent
    blank_when_idle: assert property (@(posedge pixel_clk) disable iff (!rst_pixel_n)
        !hdmi_de_o |-> (hdmi_d_o == BLANK_WORD))
    else begin
        fail_count = fail_count + 1;
        $error("hdmi_d_o differs from the blanking word while hdmi_de_o is low");
    end

    // No active pixel inside either sync pulse
    de_outside_sync: assert property (@(posedge pixel_clk) disable iff (!rst_pixel_n)
        hdmi_de_o |-> (hdmi_hsync_o && hdmi_vsync_o))
    else begin
        fail_count = fail_count + 1;
        $error("hdmi_de_o is high while a sync output is low");
    end

    // Whole hsync pulse, counted from its first low cycle
    hsync_width: assert property (@(posedge pixel_clk) disable iff (!rst_pixel_n)
        $fell(hdmi_hsync_o) |-> (!hdmi_hsync_o) [*H_SYNC] ##1 hdmi_hsync_o)
    else begin
        fail_count = fail_count + 1;
        $error("hdmi_hsync_o pulse is not %0d cycles long", H_SYNC);
    end

endmodule

bind hdmi_video_top hdmi_video_properties #(
    .H_SYNC (H_SYNC)
) hdmi_video_properties_inst (
    .pixel_clk    (pixel_clk),
    .rst_pixel_n  (rst_pixel_n),
    .hdmi_d_o     (hdmi_d_o),
    .hdmi_de_o    (hdmi_de_o),
    .hdmi_hsync_o (hdmi_hsync_o),
    .hdmi_vsync_o (hdmi_vsync_o)
);

`default_nettype wire

// File: tests/hdmi_video_tb.sv
/*
 * Testbench for the HDMI video path on a reduced 80x16 raster.
 * Outputs are sampled on the falling edge, where inputs also change.
 * The pattern mode only moves while hdmi_vsync_o is low, so each
 * frame is checked against the mode present at the rising vsync edge.
 */
`default_nettype none

module hdmi_video_tb;

    import video_timing_pkg::*;
    import pixel_pkg::*;

    localparam int H_ACTIVE = 64;
    localparam int H_FP     = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BP     = 4;
    localparam int V_ACTIVE = 10;
    localparam int V_FP     = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 2;
    localparam int RECT_X0  = 20;
    localparam int RECT_X1  = 35;
    localparam int RECT_Y0  = 3;
    localparam int RECT_Y1  = 6;

    localparam int H_TOTAL        = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL        = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int NUM_FRAMES     = 6;
    localparam int TIMEOUT_CYCLES = 10 * FRAME_CYCLES;

    localparam rgb565_t     RED   = '{r: 5'd31, g: 6'd0, b: 5'd0};
    localparam ycbcr_word_t BLANK = '{c: 8'd128, y: 8'd16};

    logic          pixel_clk;
    logic          rst_pixel_n;
    pattern_mode_t pattern_mode_i;
    ycbcr_word_t   hdmi_d_o;
    logic          hdmi_de_o;
    logic          hdmi_hsync_o;
    logic          hdmi_vsync_o;

    int            seed;
    int            error_count;
    int            n_checks;
    int            cycle_count;
    int            frames_done;
    int            pixels_checked;
    pattern_mode_t mode_list [NUM_FRAMES];

    // Reset level as the DUT saw it at the last rising edge
    logic          rst_seen_n;

    // Output raster tracker state
    pattern_mode_t frame_mode;
    int            y_cnt;
    int            run_len;
    int            runs_in_frame;
    int            hs_len;
    int            vs_len;
    int            line_cyc;
    logic          line_seen;
    logic          prev_de;
    logic          prev_hsync;
    logic          prev_vsync;

    hdmi_video_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP),
        .RECT_X0  (RECT_X0),
        .RECT_X1  (RECT_X1),
        .RECT_Y0  (RECT_Y0),
        .RECT_Y1  (RECT_Y1)
    ) hdmi_video_top_inst (
        .pixel_clk      (pixel_clk),
        .rst_pixel_n    (rst_pixel_n),
        .pattern_mode_i (pattern_mode_i),
        .hdmi_d_o       (hdmi_d_o),
        .hdmi_de_o      (hdmi_de_o),
        .hdmi_hsync_o   (hdmi_hsync_o),
        .hdmi_vsync_o   (hdmi_vsync_o)
    );

    always #2 pixel_clk = ~pixel_clk;

    always @(posedge pixel_clk) begin
        rst_seen_n <= rst_pixel_n;
    end

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic rgb565_t expected_rgb(input int x, input int y,
                                             input pattern_mode_t mode);
        coord_t  xb;
        coord_t  yb;
        rgb565_t pix;
        xb    = coord_t'(x);
        yb    = coord_t'(y);
        pix.r = xb[9:5];
        pix.g = yb[8:3];
        pix.b = (xb[5] != yb[5]) ? 5'd31 : 5'd0;
        if (mode == PAT_BLACK) begin
            pix = '0;
        end else if (mode == PAT_GRADIENT_RECT && x >= RECT_X0 && x <= RECT_X1 &&
                     y >= RECT_Y0 && y <= RECT_Y1) begin
            pix = RED;
        end
        return pix;
    endfunction

    // Even pixels of a run carry Cb, odd pixels Cr
    function automatic ycbcr_word_t expected_word(input int x, input int y,
                                                  input pattern_mode_t mode);
        rgb565_t     pix;
        int          r8;
        int          g8;
        int          b8;
        int          luma;
        int          cb;
        int          cr;
        ycbcr_word_t word;
        pix    = expected_rgb(x, y, mode);
        r8     = pix.r * 8 + pix.r / 4;
        g8     = pix.g * 4 + pix.g / 16;
        b8     = pix.b * 8 + pix.b / 4;
        luma   = 16 + ((66 * r8 + 129 * g8 + 25 * b8 + 128) >>> 8);
        cb     = 128 + ((-38 * r8 - 74 * g8 + 112 * b8 + 128) >>> 8);
        cr     = 128 + ((112 * r8 - 94 * g8 - 18 * b8 + 128) >>> 8);
        word.y = 8'(luma);
        word.c = (x % 2 == 1) ? 8'(cr) : 8'(cb);
        return word;
    endfunction

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic check_word(input string name, input ycbcr_word_t got,
                              input ycbcr_word_t exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_length(input string name, input int got, input int exp);
        n_checks = n_checks + 1;
        if (got != exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic flag_error(input string what);
        error_count = error_count + 1;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic check_reset_outputs();
        check_bit("hdmi_de_o", hdmi_de_o, 1'b0);
        check_bit("hdmi_hsync_o", hdmi_hsync_o, 1'b1);
        check_bit("hdmi_vsync_o", hdmi_vsync_o, 1'b1);
        check_word("hdmi_d_o", hdmi_d_o, BLANK);
    endtask

    // ======================================================================
    // Output raster tracking and compare
    // ======================================================================
    always @(negedge pixel_clk) begin
        if (!rst_seen_n) begin
            frame_mode    = pattern_mode_i;
            y_cnt         = 0;
            run_len       = 0;
            runs_in_frame = 0;
            hs_len        = 0;
            vs_len        = 0;
            line_cyc      = 0;
            line_seen     = 1'b0;
            prev_de       = 1'b0;
            prev_hsync    = 1'b1;
            prev_vsync    = 1'b1;
        end else begin
            line_cyc = line_cyc + 1;
            if (prev_hsync && !hdmi_hsync_o) begin
                if (line_seen) begin
                    check_length("line period", line_cyc, H_TOTAL);
                end
                line_cyc  = 0;
                line_seen = 1'b1;
            end
            if (!hdmi_hsync_o) begin
                hs_len = hs_len + 1;
            end else if (!prev_hsync) begin
                check_length("hsync pulse length", hs_len, H_SYNC);
                hs_len = 0;
            end

            // Rising vsync closes a frame and opens the next one
            if (!hdmi_vsync_o) begin
                vs_len = vs_len + 1;
            end else if (!prev_vsync) begin
                check_length("vsync pulse length", vs_len, V_SYNC * H_TOTAL);
                check_length("active runs per frame", runs_in_frame, V_ACTIVE);
                vs_len        = 0;
                runs_in_frame = 0;
                y_cnt         = 0;
                frame_mode    = pattern_mode_i;
                frames_done   = frames_done + 1;
            end

            if (hdmi_de_o) begin
                if (y_cnt >= V_ACTIVE) begin
                    flag_error("active pixel seen below the last active line");
                end else begin
                    check_word("hdmi_d_o", hdmi_d_o, expected_word(run_len, y_cnt, frame_mode));
                end
                check_bit("hdmi_hsync_o", hdmi_hsync_o, 1'b1);
                check_bit("hdmi_vsync_o", hdmi_vsync_o, 1'b1);
                pixels_checked = pixels_checked + 1;
                run_len        = run_len + 1;
            end else begin
                check_word("hdmi_d_o", hdmi_d_o, BLANK);
                if (prev_de) begin
                    check_length("active run length", run_len, H_ACTIVE);
                    run_len       = 0;
                    y_cnt         = y_cnt + 1;
                    runs_in_frame = runs_in_frame + 1;
                end
            end

            prev_de    = hdmi_de_o;
            prev_hsync = hdmi_hsync_o;
            prev_vsync = hdmi_vsync_o;
        end
    end

    always @(posedge pixel_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // ======================================================================
    // Stimulus and report
    // ======================================================================
    initial begin
        int            i;
        int            j;
        int            k;
        int            delay;
        int            errors_before;
        int            assert_fails;
        pattern_mode_t swap;
        string         note;

        seed           = 42676;
        error_count    = 0;
        n_checks       = 0;
        cycle_count    = 0;
        frames_done    = 0;
        pixels_checked = 0;
        mode_list      = '{PAT_GRADIENT, PAT_GRADIENT_RECT, PAT_BLACK,
                           PAT_GRADIENT, PAT_GRADIENT_RECT, PAT_BLACK};

        // Shuffle so the order of mode changes varies with the seed
        for (i = NUM_FRAMES - 1; i > 0; i = i - 1) begin
            j            = $unsigned($random(seed)) % (i + 1);
            swap         = mode_list[i];
            mode_list[i] = mode_list[j];
            mode_list[j] = swap;
        end

        rst_seen_n     = 1'b0;
        pixel_clk      = 1'b0;
        rst_pixel_n    = 1'b0;
        pattern_mode_i = mode_list[0];

        errors_before = error_count;
        repeat (10) begin
            @(negedge pixel_clk);
            check_reset_outputs();
        end
        rst_pixel_n = 1'b1;
        @(negedge pixel_clk);
        check_reset_outputs();
        $display("Test reset values: %0d errors", error_count - errors_before);

        for (k = 0; k < NUM_FRAMES; k = k + 1) begin
            errors_before = error_count;
            if (k + 1 < NUM_FRAMES) begin
                // Next mode goes in somewhere inside the vsync pulse
                while (hdmi_vsync_o !== 1'b0) begin
                    @(negedge pixel_clk);
                end
                delay = $unsigned($random(seed)) % (V_SYNC * H_TOTAL - 10);
                repeat (delay) @(negedge pixel_clk);
                pattern_mode_i = mode_list[k + 1];
            end
            // Frame count moves on falling edges, so it is read on rising ones
            while (frames_done <= k) begin
                @(posedge pixel_clk);
            end
            if (k == 0) begin
                note = "set during reset";
            end else begin
                note = $sformatf("changed from %s", mode_list[k - 1].name());
            end
            $display("Test frame %0d, mode %s (%s): %0d errors", k,
                     mode_list[k].name(), note, error_count - errors_before);
        end

        if (pixels_checked != NUM_FRAMES * H_ACTIVE * V_ACTIVE) begin
            flag_error($sformatf("only %0d active pixels were compared, %0d expected",
                                 pixels_checked, NUM_FRAMES * H_ACTIVE * V_ACTIVE));
        end
        assert_fails = hdmi_video_top_inst.hdmi_video_properties_inst.fail_count;
        if (assert_fails != 0) begin
            flag_error($sformatf("bound assertions failed %0d times", assert_fails));
        end

        $display("Summary: %0d checks, %0d errors, %0d frames", n_checks, error_count,
                 frames_done);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/video_timing_pkg.sv
logic/pixel_pkg.sv
logic/video_timing_gen.sv
logic/test_pattern_source.sv
logic/rgb_to_ycbcr422.sv
logic/hdmi_video_top.sv
tests/hdmi_video_properties.sv
tests/hdmi_video_tb.sv
